//--- Makefile
# Verilator build and run for the bit-manipulation unit testbench
VERILATOR ?= verilator
TOP       ?= bmu_tb
FLAGS     ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir

FILELIST := verilog.f
SRCS     := $(shell grep -v '^+' $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

//--- design/bmu_ctrl.sv
// control FSM, operand capture and completion pulse
// start_i is only taken in idle with no result pending, no back-pressure
// done_o comes one cycle after the operation finishes (or is trapped)
`timescale 1ns/1ns
`default_nettype none

module bmu_ctrl import bmu_pkg::*; (
  input  logic      clk_i,
  input  logic      rstn_i,
  input  logic      start_i,
  input  logic      trap_i,
  input  op_e       op_i,
  input  word_t     rs1_i,
  input  word_t     rs2_i,
  input  shamt_t    shamt_i,
  input  logic      less_i,
  input  logic      mul_busy_i,
  output op_e       op_o,
  output operands_t opnd_o,
  output logic      mul_start_o,
  output logic      done_o
);

  typedef enum logic [1:0] {S_IDLE, S_START_MUL, S_BUSY_MUL} state_e;

  state_e state_q;
  logic   fin_q;   // operation finished, done_o follows
  logic   accept;  // start taken this cycle
  logic   is_mul;

  assign accept = (state_q == S_IDLE) && start_i && !fin_q;
  assign is_mul = op_i inside {OP_CLMUL, OP_CLMULH, OP_CLMULR};

  // FSM ---------------------------
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q     <= S_IDLE;
      op_o        <= OP_NONE;
      mul_start_o <= 1'b0;
      fin_q       <= 1'b0;
      done_o      <= 1'b0;
    end else begin
      mul_start_o <= 1'b0; // pulses
      fin_q       <= 1'b0;
      done_o      <= fin_q;
      case (state_q)
        S_IDLE: begin
          if (accept) begin
            op_o <= op_i;
            if (is_mul) begin
              mul_start_o <= 1'b1;
              state_q     <= S_START_MUL;
            end else begin
              fin_q <= 1'b1; // single cycle op
            end
          end
        end
        S_START_MUL: begin // multiplier loads on this edge
          if (trap_i) begin
            fin_q   <= 1'b1;
            state_q <= S_IDLE;
          end else begin
            state_q <= S_BUSY_MUL;
          end
        end
        S_BUSY_MUL: begin
          if (!mul_busy_i || trap_i) begin // done or aborted
            fin_q   <= 1'b1;
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // operand capture ---------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      opnd_o.rs1   <= rs1_i;
      opnd_o.rs2   <= rs2_i;
      opnd_o.shamt <= shamt_i;
      opnd_o.less  <= less_i;
    end
  end

endmodule

`default_nettype wire

//--- design/bmu_decode.sv
// instruction field decode, purely combinational
// only funct7, rs2 field and funct3 are looked at, opcode is checked by the core
`timescale 1ns/1ns
`default_nettype none

module bmu_decode import bmu_pkg::*; (
  input  instr_t instr_i,
  output op_e    op_o
);

  logic [6:0] funct7;
  logic [4:0] rs2_f;   // rs2 field, selects unary ops
  funct3_t    f3;

  assign funct7 = instr_i.funct12[11:5];
  assign rs2_f  = instr_i.funct12[4:0];
  assign f3     = instr_i.funct3;

  always_comb begin
    op_o = OP_NONE; // anything unmatched
    case (funct7)
      7'b0100000: begin // logic with negate
        if (f3 == 3'd7) op_o = OP_ANDN;
        else if (f3 == 3'd6) op_o = OP_ORN;
        else if (f3 == 3'd4) op_o = OP_XNOR;
      end
      7'b0000101: begin // min/max and clmul share funct7
        case (f3)
          3'd1: op_o = OP_CLMUL;
          3'd2: op_o = OP_CLMULR;
          3'd3: op_o = OP_CLMULH;
          3'd4: op_o = OP_MIN;
          3'd5: op_o = OP_MINU;
          3'd6: op_o = OP_MAX;
          3'd7: op_o = OP_MAXU;
          default: op_o = OP_NONE;
        endcase
      end
      7'b0010000: begin // shNadd
        if (f3 == 3'd2) op_o = OP_SH1ADD;
        else if (f3 == 3'd4) op_o = OP_SH2ADD;
        else if (f3 == 3'd6) op_o = OP_SH3ADD;
      end
      7'b0100100: begin
        if (f3 == 3'd1) op_o = OP_BCLR;
        else if (f3 == 3'd5) op_o = OP_BEXT;
      end
      7'b0110100: begin
        if (f3 == 3'd1) op_o = OP_BINV;
        else if (f3 == 3'd5 && rs2_f == 5'b11000) op_o = OP_REV8;
      end
      7'b0010100: begin
        if (f3 == 3'd1) op_o = OP_BSET;
        else if (f3 == 3'd5 && rs2_f == 5'b00111) op_o = OP_ORCB;
      end
      7'b0110000: begin // sign extension, rs2 field picks width
        if (f3 == 3'd1 && rs2_f == 5'd4) op_o = OP_SEXTB;
        else if (f3 == 3'd1 && rs2_f == 5'd5) op_o = OP_SEXTH;
      end
      7'b0000100: begin
        if (f3 == 3'd4 && rs2_f == 5'd0) op_o = OP_ZEXTH;
      end
      default: op_o = OP_NONE;
    endcase
  end

endmodule

`default_nettype wire

//--- design/bmu_exec_clmul.sv
// iterative carry-less multiplier, one bit of rs1 per cycle
// 32 steps after the load cycle; op and operands must stay stable meanwhile
// a new start reloads even while busy
`timescale 1ns/1ns
`default_nettype none

module bmu_exec_clmul import bmu_pkg::*; (
  input  logic              clk_i,
  input  logic              rstn_i,
  input  logic              start_i,
  input  op_e               op_i,
  input  operands_t         opnd_i,
  output logic              busy_o,
  output logic [2*XLEN-1:0] prod_o
);

  logic [SHAMT_W:0]  cnt_q;  // steps left, 0..32
  logic [2*XLEN-1:0] prod_q; // hi: accumulator, lo: remaining rs1 bits
  logic              rev;    // clmulr works on reversed operands
  word_t             rs1_m;
  word_t             rs2_m;
  word_t             hi_mix;

  assign rev   = (op_i == OP_CLMULR);
  assign rs1_m = rev ? {<<{opnd_i.rs1}} : opnd_i.rs1;
  assign rs2_m = rev ? {<<{opnd_i.rs2}} : opnd_i.rs2;

  // add (xor) rs2 into the upper half when the current bit is set
  assign hi_mix = prod_q[0] ? (prod_q[2*XLEN-1:XLEN] ^ rs2_m) : prod_q[2*XLEN-1:XLEN];

  // step counter ------------------
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= (SHAMT_W+1)'(XLEN);
    end else if (busy_o) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // product shift register --------
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      prod_q <= {{XLEN{1'b0}}, rs1_m};
    end else if (busy_o) begin
      prod_q <= {1'b0, hi_mix, prod_q[XLEN-1:1]}; // shift right one
    end
  end

  assign busy_o = |cnt_q;
  assign prod_o = prod_q;

endmodule

`default_nettype wire

//--- design/bmu_exec_logic.sv
// single-cycle Zbb/Zba/Zbs results from the held operands
// output is 0 for clmul ops and OP_NONE
`timescale 1ns/1ns
`default_nettype none

module bmu_exec_logic import bmu_pkg::*; (
  input  op_e       op_i,
  input  operands_t opnd_i,
  output word_t     res_o
);

  word_t rs1;
  word_t rs2;
  word_t one_hot;  // single-bit mask from shamt
  word_t sh_opb;   // rs1 shifted for shNadd
  word_t sh_sum;
  word_t orcb;
  logic  is_max;

  assign rs1 = opnd_i.rs1;
  assign rs2 = opnd_i.rs2;

  // one-hot generator -------------
  always_comb begin
    one_hot = '0;
    one_hot[opnd_i.shamt] = 1'b1;
  end

  // shifted adder -----------------
  always_comb begin
    case (op_i)
      OP_SH1ADD: sh_opb = {rs1[XLEN-2:0], 1'b0};
      OP_SH2ADD: sh_opb = {rs1[XLEN-3:0], 2'b0};
      default:   sh_opb = {rs1[XLEN-4:0], 3'b0}; // sh3add
    endcase
  end

  assign sh_sum = rs2 + sh_opb;

  // or-combine, each byte to all ones if any bit set
  for (genvar b = 0; b < XLEN/8; b++) begin : g_orcb
    assign orcb[b*8 +: 8] = {8{|rs1[b*8 +: 8]}};
  end

  // less already holds signedness, so min/minu and max/maxu collapse
  assign is_max = op_i inside {OP_MAX, OP_MAXU};

  // result select -----------------
  always_comb begin
    case (op_i)
      OP_ANDN:  res_o = rs1 & ~rs2;
      OP_ORN:   res_o = rs1 | ~rs2;
      OP_XNOR:  res_o = rs1 ^ ~rs2;
      OP_MIN, OP_MAX, OP_MINU, OP_MAXU: begin
        res_o = (opnd_i.less ^ is_max) ? rs1 : rs2;
      end
      OP_SEXTB: res_o = {{(XLEN-8){rs1[7]}}, rs1[7:0]};
      OP_SEXTH: res_o = {{(XLEN-16){rs1[15]}}, rs1[15:0]};
      OP_ZEXTH: res_o = {{(XLEN-16){1'b0}}, rs1[15:0]};
      OP_ORCB:  res_o = orcb;
      OP_REV8:  res_o = {<<8{rs1}}; // byte swap
      OP_SH1ADD, OP_SH2ADD, OP_SH3ADD: begin
        res_o = sh_sum;
      end
      OP_BCLR:  res_o = rs1 & ~one_hot;
      OP_BEXT:  res_o = {{(XLEN-1){1'b0}}, |(rs1 & one_hot)};
      OP_BINV:  res_o = rs1 ^ one_hot;
      OP_BSET:  res_o = rs1 | one_hot;
      default:  res_o = '0; // clmul, none
    endcase
  end

endmodule

`default_nettype wire

//--- design/bmu_pkg.sv
// shared types for the bit-manipulation unit
// data path fixed at 32 bits (RV32 B encodings only)
`default_nettype none

package bmu_pkg;

  localparam int XLEN    = 32; // data width
  localparam int SHAMT_W = 5;  // bit index width, log2(XLEN)

  typedef logic [XLEN-1:0]    word_t;
  typedef logic [SHAMT_W-1:0] shamt_t;
  typedef logic [11:0]        funct12_t; // funct7 & rs2 field
  typedef logic [2:0]         funct3_t;

  // instruction fields as seen by the unit
  typedef struct packed {
    funct12_t funct12;
    funct3_t  funct3;
  } instr_t;

  // decoded operation, one value per kept instruction
  typedef enum logic [4:0] {
    OP_NONE,
    OP_ANDN, OP_ORN, OP_XNOR,
    OP_MIN, OP_MAX, OP_MINU, OP_MAXU,  // signedness comes with the less flag
    OP_SEXTB, OP_SEXTH, OP_ZEXTH,
    OP_ORCB, OP_REV8,
    OP_SH1ADD, OP_SH2ADD, OP_SH3ADD,
    OP_BCLR, OP_BEXT, OP_BINV, OP_BSET,
    OP_CLMUL, OP_CLMULH, OP_CLMULR
  } op_e;

  // operands held for the whole operation
  typedef struct packed {
    word_t  rs1;
    word_t  rs2;
    shamt_t shamt;
    logic   less; // external comparator result
  } operands_t;

endpackage

`default_nettype wire

//--- design/bmu_result.sv
// final result mux and output registers
// res_o is forced to 0 in every cycle valid_o is low
`timescale 1ns/1ns
`default_nettype none

module bmu_result import bmu_pkg::*; (
  input  logic              clk_i,
  input  logic              rstn_i,
  input  logic              done_i,
  input  op_e               op_i,
  input  word_t             logic_res_i,
  input  logic [2*XLEN-1:0] prod_i,
  output word_t             res_o,
  output logic              valid_o
);

  word_t res_sel;

  always_comb begin
    case (op_i)
      OP_CLMUL:  res_sel = prod_i[XLEN-1:0];      // low half
      OP_CLMULH: res_sel = prod_i[2*XLEN-1:XLEN]; // high half
      OP_CLMULR: res_sel = {<<{prod_i[XLEN-1:0]}}; // undo operand reversal
      default:   res_sel = logic_res_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      res_o   <= '0;
      valid_o <= 1'b0;
    end else if (done_i) begin
      res_o   <= res_sel;
      valid_o <= 1'b1;
    end else begin
      res_o   <= '0;
      valid_o <= 1'b0; // single cycle pulse
    end
  end

endmodule

`default_nettype wire

//--- design/bmu_top.sv
// bit-manipulation unit top, Zba/Zbb/Zbc/Zbs subset for RV32
// less_i must come from an external comparator with the right signedness
// latency: 2 cycles for single-cycle ops, 36 for clmul*, no back-pressure
`timescale 1ns/1ns
`default_nettype none

module bmu_top import bmu_pkg::*; (
  input  logic   clk_i,
  input  logic   rstn_i,
  input  logic   start_i,
  input  logic   trap_i,   // aborts a running clmul
  input  instr_t instr_i,
  input  word_t  rs1_i,
  input  word_t  rs2_i,
  input  shamt_t shamt_i,
  input  logic   less_i,
  output word_t  res_o,
  output logic   valid_o
);

  op_e               op;
  op_e               op_q;
  operands_t         opnd_q;
  logic              mul_start;
  logic              mul_busy;
  logic              done;
  word_t             logic_res;
  logic [2*XLEN-1:0] mul_prod;

  bmu_decode u_decode (
    .instr_i (instr_i),
    .op_o    (op)
  );

  bmu_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .start_i     (start_i),
    .trap_i      (trap_i),
    .op_i        (op),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .shamt_i     (shamt_i),
    .less_i      (less_i),
    .mul_busy_i  (mul_busy),
    .op_o        (op_q),
    .opnd_o      (opnd_q),
    .mul_start_o (mul_start),
    .done_o      (done)
  );

  bmu_exec_logic u_exec_logic (
    .op_i   (op_q),
    .opnd_i (opnd_q),
    .res_o  (logic_res)
  );

  bmu_exec_clmul u_exec_clmul (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .start_i (mul_start),
    .op_i    (op_q),
    .opnd_i  (opnd_q),
    .busy_o  (mul_busy),
    .prod_o  (mul_prod)
  );

  bmu_result u_result (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .done_i      (done),
    .op_i        (op_q),
    .logic_res_i (logic_res),
    .prod_i      (mul_prod),
    .res_o       (res_o),
    .valid_o     (valid_o)
  );

endmodule

`default_nettype wire

//--- verif/bmu_tb.sv
// self-checking testbench for bmu_top against a model of the B rules
// build with assertions enabled
// needs timing support for the free-running clock
`timescale 1ns/1ns
`default_nettype none

module bmu_tb import bmu_pkg::*; ();

  logic   clk_i;
  logic   rstn_i;
  logic   start_i;
  logic   trap_i;
  instr_t instr_i;
  word_t  rs1_i;
  word_t  rs2_i;
  shamt_t shamt_i;
  logic   less_i;
  word_t  res_o;
  logic   valid_o;

  // model state ------------------
  int    cyc = 0;      // edge counter
  int    n_valid = 0;  // valid pulses seen so far
  int    base_valid = 0;
  int    exp_lo = -1;  // window where valid_o may be sampled high
  int    exp_hi = -1;
  logic  chk_val = 1'b0; // value is undefined after a trap
  word_t exp_res = '0;

  bmu_top UUT (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc     <= cyc + 1;
    n_valid <= n_valid + (valid_o ? 1 : 0);
  end

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  // checks ------------------------
  a_res_zero: assert property (@(posedge clk_i) (cyc != 0 && !valid_o) |-> res_o == '0)
    else stop_run($sformatf("[FAIL] res_o got %h exp %h", $sampled(res_o), 32'h0));
  a_valid_time: assert property (@(posedge clk_i) valid_o |-> (cyc >= exp_lo && cyc <= exp_hi))
    else stop_run($sformatf("[FAIL] valid_o got %h exp %h at cycle %0d", 1'b1, 1'b0,
                            $sampled(cyc)));
  a_valid_due: assert property (@(posedge clk_i)
                                (cyc == exp_hi) |-> (valid_o || n_valid != base_valid))
    else stop_run($sformatf("[FAIL] valid_o got %h exp %h at cycle %0d", 1'b0, 1'b1,
                            $sampled(cyc)));
  a_valid_once: assert property (@(posedge clk_i) valid_o |-> n_valid == base_valid)
    else stop_run("a second valid_o pulse came for one operation");
  a_res_value: assert property (@(posedge clk_i) (valid_o && chk_val) |-> res_o == exp_res)
    else stop_run($sformatf("[FAIL] res_o got %h exp %h", $sampled(res_o), exp_res));

  // reference model ---------------
  function automatic logic [63:0] clmul_full(input word_t a, input word_t b);
    logic [63:0] acc;
    int          i;
    acc = '0;
    for (i = 0; i < 32; i++) begin
      if (b[i]) acc = acc ^ ({32'h0, a} << i); // xor instead of add
    end
    return acc;
  endfunction

  function automatic word_t ref_result(input op_e op, input word_t a, input word_t b,
                                       input shamt_t sh, input logic lt);
    logic [63:0] p;
    word_t       r;
    int          i;
    p = clmul_full(a, b);
    r = '0;
    case (op)
      OP_ANDN:         r = a & ~b;
      OP_ORN:          r = a | ~b;
      OP_XNOR:         r = ~(a ^ b);
      OP_MIN, OP_MINU: r = lt ? a : b; // lt means rs1 < rs2
      OP_MAX, OP_MAXU: r = lt ? b : a;
      OP_SEXTB:        r = 32'($signed(a[7:0]));
      OP_SEXTH:        r = 32'($signed(a[15:0]));
      OP_ZEXTH:        r = a & 32'h0000_ffff;
      OP_ORCB: begin
        for (i = 0; i < 4; i++) r[8*i +: 8] = (a[8*i +: 8] != 8'h0) ? 8'hff : 8'h00;
      end
      OP_REV8: begin
        for (i = 0; i < 4; i++) r[8*i +: 8] = a[8*(3-i) +: 8];
      end
      OP_SH1ADD:       r = b + (a << 1);
      OP_SH2ADD:       r = b + (a << 2);
      OP_SH3ADD:       r = b + (a << 3);
      OP_BCLR:         r = a & ~(32'h1 << sh);
      OP_BEXT:         r = (a >> sh) & 32'h1;
      OP_BINV:         r = a ^ (32'h1 << sh);
      OP_BSET:         r = a | (32'h1 << sh);
      OP_CLMUL:        r = p[31:0];
      OP_CLMULH:       r = p[63:32];
      OP_CLMULR:       r = p[62:31]; // reversed product window
      default:         r = '0;
    endcase
    return r;
  endfunction

  // funct7, rs2 field, funct3 per the ratified encodings
  function automatic instr_t encode(input op_e op, input logic [4:0] fill);
    instr_t enc;
    case (op)
      OP_ANDN:   enc = {7'b0100000, fill, 3'd7};
      OP_ORN:    enc = {7'b0100000, fill, 3'd6};
      OP_XNOR:   enc = {7'b0100000, fill, 3'd4};
      OP_MIN:    enc = {7'b0000101, fill, 3'd4};
      OP_MINU:   enc = {7'b0000101, fill, 3'd5};
      OP_MAX:    enc = {7'b0000101, fill, 3'd6};
      OP_MAXU:   enc = {7'b0000101, fill, 3'd7};
      OP_CLMUL:  enc = {7'b0000101, fill, 3'd1};
      OP_CLMULR: enc = {7'b0000101, fill, 3'd2};
      OP_CLMULH: enc = {7'b0000101, fill, 3'd3};
      OP_SH1ADD: enc = {7'b0010000, fill, 3'd2};
      OP_SH2ADD: enc = {7'b0010000, fill, 3'd4};
      OP_SH3ADD: enc = {7'b0010000, fill, 3'd6};
      OP_BCLR:   enc = {7'b0100100, fill, 3'd1};
      OP_BEXT:   enc = {7'b0100100, fill, 3'd5};
      OP_BINV:   enc = {7'b0110100, fill, 3'd1};
      OP_BSET:   enc = {7'b0010100, fill, 3'd1};
      OP_ORCB:   enc = {7'b0010100, 5'b00111, 3'd5};
      OP_REV8:   enc = {7'b0110100, 5'b11000, 3'd5};
      OP_SEXTB:  enc = {7'b0110000, 5'd4, 3'd1};
      OP_SEXTH:  enc = {7'b0110000, 5'd5, 3'd1};
      OP_ZEXTH:  enc = {7'b0000100, 5'd0, 3'd4};
      default:   enc = {7'b0000000, fill, fill[2:0]}; // funct7 0 is unused by B
    endcase
    return enc;
  endfunction

  // stimulus ----------------------
  task automatic drive_start(input op_e op, input word_t a, input word_t b,
                             input shamt_t sh, input logic lt);
    @(posedge clk_i);
    instr_i <= encode(op, 5'($urandom));
    rs1_i   <= a;
    rs2_i   <= b;
    shamt_i <= sh;
    less_i  <= lt;
    start_i <= 1'b1;
  endtask

  task automatic run_op(input op_e op);
    word_t  a;
    word_t  b;
    shamt_t sh;
    logic   lt;
    a  = $urandom;
    b  = $urandom;
    sh = 5'($urandom);
    lt = 1'($urandom);
    if (op == OP_ORCB) a = a & ~(32'hff << (8 * ($urandom % 4))); // one zero byte
    drive_start(op, a, b, sh, lt);
    base_valid = n_valid;
    exp_res = ref_result(op, a, b, sh, lt);
    chk_val = 1'b1;
    exp_lo  = cyc + ((op inside {OP_CLMUL, OP_CLMULH, OP_CLMULR}) ? 38 : 4); // +2 sample lag
    exp_hi  = exp_lo;
    @(posedge clk_i);
    start_i <= 1'b0;
  endtask

  task automatic wait_valid(input int limit);
    int waited;
    waited = 0;
    while (n_valid == base_valid && waited < limit) begin
      @(posedge clk_i);
      waited++;
    end
    if (n_valid == base_valid) stop_run("timeout while waiting for valid_o");
  endtask

  initial begin
    int n;
    int k;
    void'($urandom(23734));
    clk_i   = 1'b0;
    rstn_i  = 1'b0;
    start_i = 1'b0;
    trap_i  = 1'b0;
    instr_i = '0;
    rs1_i   = '0;
    rs2_i   = '0;
    shamt_i = '0;
    less_i  = 1'b0;
    repeat (8) @(posedge clk_i);
    rstn_i <= 1'b1;
    repeat (3) @(posedge clk_i);

    for (n = 0; n < 6; n++) begin // every single-cycle op
      for (k = OP_ANDN; k <= OP_BSET; k++) begin
        run_op(op_e'(k));
        wait_valid(10);
      end
    end
    for (n = 0; n < 4; n++) begin
      for (k = OP_CLMUL; k <= OP_CLMULR; k++) begin
        run_op(op_e'(k));
        wait_valid(50);
      end
    end

    // a start while the multiplier runs must be dropped
    run_op(OP_CLMULH);
    repeat (6) @(posedge clk_i);
    drive_start(OP_XNOR, $urandom, $urandom, 5'($urandom), 1'b0);
    @(posedge clk_i);
    start_i <= 1'b0;
    wait_valid(50);
    repeat (5) @(posedge clk_i);

    // trap mid-multiply and normal ops after it
    run_op(OP_CLMULR);
    repeat (9) @(posedge clk_i);
    trap_i  <= 1'b1;
    exp_lo  = cyc + 3;
    exp_hi  = cyc + 4;
    chk_val = 1'b0;
    @(posedge clk_i);
    trap_i <= 1'b0;
    wait_valid(10);
    run_op(OP_CLMUL);
    wait_valid(50);
    run_op(OP_SH2ADD);
    wait_valid(10);

    for (n = 0; n < 4; n++) begin // unmatched encodings
      run_op(OP_NONE);
      wait_valid(10);
    end
    repeat (4) @(posedge clk_i);

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
design/bmu_pkg.sv
design/bmu_decode.sv
design/bmu_ctrl.sv
design/bmu_exec_logic.sv
design/bmu_exec_clmul.sv
design/bmu_result.sv
design/bmu_top.sv
verif/bmu_tb.sv
